// ==== src/ql_pkg.sv ====
// shared definitions for the ql memory bus
// address map, bus widths, download entry type and timing constants
package ql_pkg;

	// --------------------------------------
	// widths
	localparam int CPU_ADDR_W   = 20;  // 68008 byte address, 1M space
	localparam int SYS_ADDR_W   = 25;  // memory word address
	localparam int VIDEO_ADDR_W = 19;  // video fetch word address
	localparam int BUS_DATA_W   = 16;
	localparam int DL_INDEX_W   = 5;

	typedef logic [CPU_ADDR_W-1:0]   cpu_addr_t;
	typedef logic [SYS_ADDR_W-1:0]   sys_addr_t;
	typedef logic [VIDEO_ADDR_W-1:0] video_addr_t;
	typedef logic [BUS_DATA_W-1:0]   bus_data_t;
	typedef logic [DL_INDEX_W-1:0]   dl_index_t;

	// one buffered download write
	typedef struct packed {
		sys_addr_t addr;  // target word address
		bus_data_t data;
	} dl_entry_t;

	// --------------------------------------
	// cpu address map
	localparam logic [5:0] IO_BASE_PAGE = 6'h06;  // a[19:14], internal i/o $18000-$1bfff
	localparam logic [2:0] BRAM_PAGE    = 3'b001; // a[19:17], 128k base ram at $20000
	localparam logic [3:0] ROM_PAGE     = 4'h0;   // a[19:16], 64k rom at $0
	localparam logic [5:0] QIMI_PAGE    = 6'h3f;  // a[13:8], mouse at $1bfxx

	localparam bus_data_t IO_IDLE_DATA = 16'hffff;  // unmapped reads

	// --------------------------------------
	// download buffer
	localparam dl_index_t DL_INDEX_ROM0 = 5'd0;  // both indices load rom images
	localparam dl_index_t DL_INDEX_ROM3 = 5'd3;
	localparam int DL_FIFO_DEPTH = 4;
	localparam int DL_PTR_W      = $clog2(DL_FIFO_DEPTH);
	localparam int DL_COUNT_W    = $clog2(DL_FIFO_DEPTH + 1);  // holds 0..depth

	// core reset stretch
	localparam int RESET_HOLD_CYCLES = 255;
	localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);

endpackage

// ==== src/mem_req_if.sv ====
// memory request bundle between the cpu decoder and the slot scheduler
`timescale 1ns/1ps

interface mem_req_if;
	import ql_pkg::*;

	sys_addr_t addr;   // word address
	bus_data_t wdata;  // write data
	logic      we;     // write request
	logic      oe;     // read request
	logic      uds;    // upper byte enable
	logic      lds;    // lower byte enable

	// request producer
	modport source (
		output addr, wdata, we, oe, uds, lds
	);

	// request consumer
	modport sink (
		input addr, wdata, we, oe, uds, lds
	);

endinterface

// ==== src/cpu_bus_decoder.sv ====
// cpu address decode, memory request forming, i/o selects
// and read data return mux
`timescale 1ns/1ps

module cpu_bus_decoder (
	input  ql_pkg::cpu_addr_t cpu_addr,
	input  ql_pkg::bus_data_t cpu_wdata,
	input  logic              cpu_rd,       // code or data read
	input  logic              cpu_wr,       // data write
	input  logic              cpu_uds,
	input  logic              cpu_lds,
	input  logic              ram_640k,     // enables extended ram
	input  ql_pkg::bus_data_t mem_rdata,
	input  ql_pkg::bus_data_t zx8302_rdata,
	input  logic [7:0]        qimi_rdata,
	output ql_pkg::bus_data_t cpu_rdata,
	output logic              zx8301_cs,    // video mode register write
	output logic              zx8302_sel,
	output logic              qimi_sel,
	mem_req_if.source         req
);
	import ql_pkg::*;

	logic      cpu_act;
	logic      cpu_io;
	logic      cpu_bram;
	logic      cpu_xram;
	logic      cpu_ram;
	logic      cpu_rom;
	logic      cpu_mem;
	logic      xram_page;
	bus_data_t io_rdata;

	// area classification
	assign cpu_act   = cpu_rd || cpu_wr;
	assign cpu_io    = cpu_act && (cpu_addr[19:14] == IO_BASE_PAGE);
	assign cpu_bram  = cpu_act && (cpu_addr[19:17] == BRAM_PAGE);
	assign xram_page = (cpu_addr[19:18] == 2'b01) || (cpu_addr[19:18] == 2'b10);  // $40000-$bffff
	assign cpu_xram  = cpu_act && ram_640k && xram_page;
	assign cpu_ram   = cpu_bram || cpu_xram;
	assign cpu_rom   = cpu_act && (cpu_addr[19:16] == ROM_PAGE);
	assign cpu_mem   = cpu_ram || cpu_rom;  // anything held in memory

	// --------------------------------------
	// memory request
	assign req.addr  = sys_addr_t'(cpu_addr[CPU_ADDR_W-1:1]);  // byte to word address
	assign req.wdata = cpu_wdata;
	assign req.we    = cpu_wr && cpu_ram;  // rom is never written by the cpu
	assign req.oe    = cpu_rd && cpu_mem;
	assign req.uds   = cpu_uds;
	assign req.lds   = cpu_lds;

	// --------------------------------------
	// i/o selects
	// zx8301 has a single write-only register at $18063
	assign zx8301_cs  = cpu_io && ({cpu_addr[6:5], cpu_addr[1]} == 3'b111) && cpu_wr && cpu_lds;
	assign zx8302_sel = cpu_io && !cpu_addr[6];
	assign qimi_sel   = cpu_io && (cpu_addr[13:8] == QIMI_PAGE);

	// i/o read data
	always_comb begin
		if (qimi_sel)
			io_rdata = {qimi_rdata, qimi_rdata};  // byte wide device, both lanes
		else if (!cpu_addr[6])
			io_rdata = zx8302_rdata;
		else
			io_rdata = '0;  // write-only area
	end

	// return mux to the cpu
	always_comb begin
		if (cpu_mem)
			cpu_rdata = mem_rdata;
		else if (cpu_io)
			cpu_rdata = io_rdata;
		else
			cpu_rdata = IO_IDLE_DATA;  // nothing mapped here
	end

endmodule

// ==== src/download_fifo.sv ====
// circular buffer for download writes waiting for a cpu slot
`timescale 1ns/1ps

module download_fifo (
	input  logic              clk2,
	input  logic              reset,
	input  logic              push,        // single-cycle write strobe
	input  ql_pkg::dl_entry_t push_entry,
	input  logic              pop,
	output ql_pkg::dl_entry_t head,        // oldest entry
	output logic              empty,
	output logic              overflow     // sticky, a write was lost
);
	import ql_pkg::*;

	dl_entry_t             mem [DL_FIFO_DEPTH];
	logic [DL_PTR_W-1:0]   wr_ptr;
	logic [DL_PTR_W-1:0]   rd_ptr;
	logic [DL_COUNT_W-1:0] count;   // occupancy
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full    = (count == DL_COUNT_W'(DL_FIFO_DEPTH));
	assign empty   = (count == '0);
	assign do_push = push && !full;  // strobe while full is dropped
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];

	// entry storage
	always_ff @(posedge clk2) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	// pointers, count and overflow flag
	always_ff @(posedge clk2) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == DL_PTR_W'(DL_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == DL_PTR_W'(DL_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or push and pop together
			endcase
			if (push && full)
				overflow <= 1'b1;
		end
	end

endmodule

// ==== src/slot_scheduler.sv ====
// cpu/video slot alternation, download drain and
// the registered memory request
`timescale 1ns/1ps

module slot_scheduler (
	input  logic                clk2,
	input  logic                reset,
	mem_req_if.sink             cpu_req,
	input  logic                cpu_idle,      // cpu bus cycle without memory access
	input  logic                dio_download,
	input  ql_pkg::dl_entry_t   dl_head,
	input  logic                dl_empty,
	input  ql_pkg::video_addr_t video_addr,
	input  logic                video_rd,
	input  logic                mdv_read,
	input  logic                mdv2_read,
	input  logic                mdv_seldrive,  // 1 selects microdrive 2
	input  ql_pkg::sys_addr_t   mdv_addr,
	input  ql_pkg::sys_addr_t   mdv2_addr,
	output logic                video_cycle,
	output logic                cpu_enable,
	output logic                dl_pop,
	output ql_pkg::sys_addr_t   mem_addr,
	output ql_pkg::bus_data_t   mem_wdata,
	output logic                mem_we,
	output logic                mem_oe,
	output logic                mem_uds,
	output logic                mem_lds,
	output logic                mem_video_slot
);
	import ql_pkg::*;

	sys_addr_t next_addr;
	bus_data_t next_wdata;
	logic      next_we;
	logic      next_oe;
	logic      next_uds;
	logic      next_lds;
	logic      mdv_any;

	assign mdv_any = mdv_read || mdv2_read;  // only one drive is active at a time

	// one buffered write per cpu slot
	assign dl_pop = !video_cycle && !dl_empty;

	// slot toggle, cpu slot first after reset
	always_ff @(posedge clk2) begin
		if (reset)
			video_cycle <= 1'b0;
		else
			video_cycle <= !video_cycle;
	end

	// --------------------------------------
	// request selection for the current slot
	always_comb begin
		next_addr  = cpu_req.addr;
		next_wdata = cpu_req.wdata;
		next_we    = 1'b0;
		next_oe    = 1'b0;
		next_uds   = 1'b0;
		next_lds   = 1'b0;
		if (video_cycle) begin
			next_uds = 1'b1;  // full word fetch, never a write
			next_lds = 1'b1;
			if (mdv_any) begin
				next_addr = mdv_seldrive ? mdv2_addr : mdv_addr;  // microdrive wins the slot
				next_oe   = 1'b1;
			end else begin
				next_addr = sys_addr_t'(video_addr);
				next_oe   = video_rd;
			end
		end else if (!dl_empty) begin
			next_addr  = dl_head.addr;  // drain download buffer
			next_wdata = dl_head.data;
			next_we    = 1'b1;
			next_uds   = 1'b1;
			next_lds   = 1'b1;
		end else if (!dio_download) begin
			next_we  = cpu_req.we;
			next_oe  = cpu_req.oe;
			next_uds = cpu_req.uds;
			next_lds = cpu_req.lds;
		end
	end

	// --------------------------------------
	// registered request, one clock behind its slot
	always_ff @(posedge clk2) begin
		mem_addr  <= next_addr;
		mem_wdata <= next_wdata;
	end

	always_ff @(posedge clk2) begin
		if (reset) begin
			mem_we         <= 1'b0;
			mem_oe         <= 1'b0;
			mem_uds        <= 1'b0;
			mem_lds        <= 1'b0;
			mem_video_slot <= 1'b0;
			cpu_enable     <= 1'b0;
		end else begin
			mem_we         <= next_we;
			mem_oe         <= next_oe;
			mem_uds        <= next_uds;
			mem_lds        <= next_lds;
			mem_video_slot <= video_cycle;
			// aligned with the request so the core advances together with its read data
			cpu_enable     <= cpu_idle || (!video_cycle && !dio_download && dl_empty);
		end
	end

endmodule

// ==== src/reset_sequencer.sv ====
// core reset stretch after external reset or rom download
`timescale 1ns/1ps

module reset_sequencer (
	input  logic             clk2,
	input  logic             reset,
	input  logic             dio_download,
	input  ql_pkg::dl_index_t dio_index,
	output logic             core_reset
);
	import ql_pkg::*;

	logic [RESET_CNT_W-1:0] hold_cnt;  // clocks of reset still to go
	logic                   rom_download;

	// a new rom image restarts the machine
	assign rom_download = dio_download &&
		((dio_index == DL_INDEX_ROM0) || (dio_index == DL_INDEX_ROM3));

	always_ff @(posedge clk2) begin
		if (reset || rom_download)
			hold_cnt <= RESET_CNT_W'(RESET_HOLD_CYCLES);  // reload while held
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign core_reset = (hold_cnt != '0);

endmodule

// ==== src/ql_memory_bus.sv ====
// top level of the shared memory bus
// cpu decoder, download buffer, slot scheduler and reset sequencer
`timescale 1ns/1ps

module ql_memory_bus (
	input  logic                clk2,
	input  logic                reset,
	// cpu bus
	input  ql_pkg::cpu_addr_t   cpu_addr,
	input  ql_pkg::bus_data_t   cpu_wdata,
	input  logic                cpu_rd,
	input  logic                cpu_wr,
	input  logic                cpu_uds,
	input  logic                cpu_lds,
	input  logic                cpu_idle,
	input  logic                ram_640k,
	output ql_pkg::bus_data_t   cpu_rdata,
	output logic                cpu_enable,
	// i/o devices
	input  ql_pkg::bus_data_t   zx8302_rdata,
	input  logic [7:0]          qimi_rdata,
	output logic                zx8301_cs,
	output logic                zx8302_sel,
	output logic                qimi_sel,
	// video and microdrive
	input  ql_pkg::video_addr_t video_addr,
	input  logic                video_rd,
	input  logic                mdv_read,
	input  logic                mdv2_read,
	input  logic                mdv_seldrive,
	input  ql_pkg::sys_addr_t   mdv_addr,
	input  ql_pkg::sys_addr_t   mdv2_addr,
	output logic                video_cycle,
	// download writes
	input  logic                dio_download,
	input  ql_pkg::dl_index_t   dio_index,
	input  logic                dio_strobe,
	input  ql_pkg::sys_addr_t   dio_addr,
	input  ql_pkg::bus_data_t   dio_data,
	output logic                dl_overflow,
	// memory request port
	input  ql_pkg::bus_data_t   mem_rdata,
	output ql_pkg::sys_addr_t   mem_addr,
	output ql_pkg::bus_data_t   mem_wdata,
	output logic                mem_we,
	output logic                mem_oe,
	output logic                mem_uds,
	output logic                mem_lds,
	output logic                mem_video_slot,
	output logic                core_reset
);
	import ql_pkg::*;

	dl_entry_t dio_entry;  // incoming download write
	dl_entry_t dl_head;
	logic      dl_empty;
	logic      dl_pop;

	mem_req_if cpu_req ();

	assign dio_entry.addr = dio_addr;
	assign dio_entry.data = dio_data;

	// --------------------------------------
	cpu_bus_decoder u_decoder (
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_rd       (cpu_rd),
		.cpu_wr       (cpu_wr),
		.cpu_uds      (cpu_uds),
		.cpu_lds      (cpu_lds),
		.ram_640k     (ram_640k),
		.mem_rdata    (mem_rdata),
		.zx8302_rdata (zx8302_rdata),
		.qimi_rdata   (qimi_rdata),
		.cpu_rdata    (cpu_rdata),
		.zx8301_cs    (zx8301_cs),
		.zx8302_sel   (zx8302_sel),
		.qimi_sel     (qimi_sel),
		.req          (cpu_req)
	);

	download_fifo u_dl_fifo (
		.clk2       (clk2),
		.reset      (reset),
		.push       (dio_strobe),
		.push_entry (dio_entry),
		.pop        (dl_pop),
		.head       (dl_head),
		.empty      (dl_empty),
		.overflow   (dl_overflow)
	);

	slot_scheduler u_scheduler (
		.clk2           (clk2),
		.reset          (reset),
		.cpu_req        (cpu_req),
		.cpu_idle       (cpu_idle),
		.dio_download   (dio_download),
		.dl_head        (dl_head),
		.dl_empty       (dl_empty),
		.video_addr     (video_addr),
		.video_rd       (video_rd),
		.mdv_read       (mdv_read),
		.mdv2_read      (mdv2_read),
		.mdv_seldrive   (mdv_seldrive),
		.mdv_addr       (mdv_addr),
		.mdv2_addr      (mdv2_addr),
		.video_cycle    (video_cycle),
		.cpu_enable     (cpu_enable),
		.dl_pop         (dl_pop),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.mem_we         (mem_we),
		.mem_oe         (mem_oe),
		.mem_uds        (mem_uds),
		.mem_lds        (mem_lds),
		.mem_video_slot (mem_video_slot)
	);

	reset_sequencer u_reset_seq (
		.clk2         (clk2),
		.reset        (reset),
		.dio_download (dio_download),
		.dio_index    (dio_index),
		.core_reset   (core_reset)
	);

endmodule

// ==== bench/tb_ql_memory_bus.sv ====
// testbench for the ql memory bus
// clock, reset, stimulus, reference model, assertions and the report
`timescale 1ns/1ps

module tb_ql_memory_bus;
	import ql_pkg::*;

	// all tests together take under 800 clocks, the limit leaves a wide margin
	localparam int MAX_CYCLES = 6000;
	localparam int AREA_NONE  = 0;
	localparam int AREA_ROM   = 1;
	localparam int AREA_IO    = 2;
	localparam int AREA_RAM   = 3;

	logic clk2, reset;
	cpu_addr_t cpu_addr;
	bus_data_t cpu_wdata, cpu_rdata, zx8302_rdata, mem_rdata, mem_wdata, dio_data;
	logic cpu_rd, cpu_wr, cpu_uds, cpu_lds, cpu_idle, ram_640k, cpu_enable;
	logic [7:0] qimi_rdata;
	logic zx8301_cs, zx8302_sel, qimi_sel;
	video_addr_t video_addr;
	logic video_rd, mdv_read, mdv2_read, mdv_seldrive, video_cycle;
	sys_addr_t mdv_addr, mdv2_addr, dio_addr, mem_addr;
	logic dio_download, dio_strobe, dl_overflow;
	dl_index_t dio_index;
	logic mem_we, mem_oe, mem_uds, mem_lds, mem_video_slot, core_reset;

	// reference model state
	logic      m_video;         // slot the model thinks is current
	dl_entry_t m_fifo [$];      // buffered download writes
	logic      m_ovf;
	int        m_hold;          // clocks of core reset still to go
	sys_addr_t exp_addr;
	bus_data_t exp_wdata, exp_rdata;
	logic      exp_we, exp_oe, exp_uds, exp_lds, exp_vslot, exp_cpu_en;
	logic      exp_8301, exp_8302, exp_qimi;
	logic      dec_act;
	int        dec_area;
	int        errors, tests, failed, cycles;

	ql_memory_bus dut (.*);

	initial begin
		clk2 = 1'b0;
		forever #10 clk2 = ~clk2;  // 50 MHz
	end

	// ----------------------------------------
	// address map of the 68008 side
	function automatic int area_of(cpu_addr_t a, logic x640);
		if (a < 20'h10000)
			return AREA_ROM;
		if (a >= 20'h18000 && a < 20'h1c000)
			return AREA_IO;
		if (a >= 20'h20000 && a < 20'h40000)
			return AREA_RAM;
		if (x640 && a >= 20'h40000 && a < 20'hc0000)
			return AREA_RAM;  // extended ram only with the 640k option
		return AREA_NONE;
	endfunction

	// combinational decode expectation
	always_comb begin
		dec_act  = cpu_rd || cpu_wr;
		dec_area = dec_act ? area_of(cpu_addr, ram_640k) : AREA_NONE;
		exp_8302 = (dec_area == AREA_IO) && !cpu_addr[6];
		exp_qimi = (dec_area == AREA_IO) && (cpu_addr >= 20'h1bf00);  // mouse page
		exp_8301 = (dec_area == AREA_IO) && cpu_wr && cpu_lds &&
			(cpu_addr[6:5] == 2'b11) && cpu_addr[1];  // mode register
		if (dec_area == AREA_ROM || dec_area == AREA_RAM)
			exp_rdata = mem_rdata;
		else if (exp_qimi)
			exp_rdata = {qimi_rdata, qimi_rdata};
		else if (exp_8302)
			exp_rdata = zx8302_rdata;
		else if (dec_area == AREA_IO)
			exp_rdata = '0;
		else
			exp_rdata = '1;  // unmapped
	end

	// registered request model, one clock behind its slot
	always @(posedge clk2) begin : ref_model
		logic      was_full;
		logic      was_empty;
		dl_entry_t ent;
		sys_addr_t n_addr;
		bus_data_t n_wdata;
		logic      n_we, n_oe, n_uds, n_lds;
		int        ar;
		if (reset) begin
			m_video <= 1'b0;
			m_fifo.delete();
			m_ovf <= 1'b0;
			m_hold <= RESET_HOLD_CYCLES;
			{exp_we, exp_oe, exp_uds, exp_lds, exp_vslot, exp_cpu_en} <= '0;
		end else begin
			was_full  = (m_fifo.size() == DL_FIFO_DEPTH);
			was_empty = (m_fifo.size() == 0);
			{n_we, n_oe, n_uds, n_lds} = '0;
			n_addr  = '0;
			n_wdata = '0;
			if (m_video) begin
				n_uds = 1'b1;
				n_lds = 1'b1;
				if (mdv_read || mdv2_read) begin
					n_addr = mdv_seldrive ? mdv2_addr : mdv_addr;
					n_oe   = 1'b1;
				end else begin
					n_addr = {6'd0, video_addr};
					n_oe   = video_rd;
				end
			end else if (!was_empty) begin
				ent     = m_fifo.pop_front();  // oldest download write
				n_addr  = ent.addr;
				n_wdata = ent.data;
				n_we    = 1'b1;
				n_uds   = 1'b1;
				n_lds   = 1'b1;
			end else if (!dio_download) begin
				ar      = area_of(cpu_addr, ram_640k);
				n_addr  = sys_addr_t'(cpu_addr >> 1);
				n_wdata = cpu_wdata;
				n_we    = cpu_wr && (ar == AREA_RAM);
				n_oe    = cpu_rd && (ar == AREA_ROM || ar == AREA_RAM);
				n_uds   = cpu_uds;
				n_lds   = cpu_lds;
			end
			if (dio_strobe) begin
				ent.addr = dio_addr;
				ent.data = dio_data;
				if (was_full)
					m_ovf <= 1'b1;  // dropped
				else
					m_fifo.push_back(ent);
			end
			exp_cpu_en <= cpu_idle || (!m_video && !dio_download && was_empty);
			m_video    <= !m_video;
			exp_vslot  <= m_video;
			exp_addr   <= n_addr;
			exp_wdata  <= n_wdata;
			{exp_we, exp_oe, exp_uds, exp_lds} <= {n_we, n_oe, n_uds, n_lds};
			if (dio_download && (dio_index == 5'd0 || dio_index == 5'd3))
				m_hold <= RESET_HOLD_CYCLES;
			else if (m_hold != 0)
				m_hold <= m_hold - 1;
		end
	end

	// ----------------------------------------
	// checks against the model
	assert property (@(posedge clk2) disable iff (reset) video_cycle == m_video)
		else begin errors++; $display("Error at %0t: video_cycle out of step", $time); end
	assert property (@(posedge clk2) disable iff (reset) mem_video_slot == exp_vslot)
		else begin errors++; $display("Error at %0t: mem_video_slot wrong", $time); end
	assert property (@(posedge clk2) disable iff (reset)
		{mem_we, mem_oe, mem_uds, mem_lds} == {exp_we, exp_oe, exp_uds, exp_lds})
		else begin
			errors++;
			$display("Error at %0t: we/oe/uds/lds %b, expected %b", $time,
				$sampled({mem_we, mem_oe, mem_uds, mem_lds}),
				$sampled({exp_we, exp_oe, exp_uds, exp_lds}));
		end
	assert property (@(posedge clk2) disable iff (reset)
		(exp_we || exp_oe) |-> (mem_addr == exp_addr))
		else begin
			errors++;
			$display("Error at %0t: mem_addr %h, expected %h", $time,
				$sampled(mem_addr), $sampled(exp_addr));
		end
	assert property (@(posedge clk2) disable iff (reset) exp_we |-> (mem_wdata == exp_wdata))
		else begin errors++; $display("Error at %0t: mem_wdata wrong", $time); end
	assert property (@(posedge clk2) disable iff (reset) cpu_enable == exp_cpu_en)
		else begin errors++; $display("Error at %0t: cpu_enable wrong", $time); end
	assert property (@(posedge clk2) disable iff (reset) dl_overflow == m_ovf)
		else begin errors++; $display("Error at %0t: dl_overflow wrong", $time); end
	assert property (@(posedge clk2) disable iff (reset) core_reset == (m_hold != 0))
		else begin errors++; $display("Error at %0t: core_reset wrong", $time); end
	assert property (@(posedge clk2) disable iff (reset) cpu_rdata == exp_rdata)
		else begin
			errors++;
			$display("Error at %0t: cpu_rdata %h, expected %h", $time,
				$sampled(cpu_rdata), $sampled(exp_rdata));
		end
	assert property (@(posedge clk2) disable iff (reset)
		{zx8301_cs, zx8302_sel, qimi_sel} == {exp_8301, exp_8302, exp_qimi})
		else begin errors++; $display("Error at %0t: i/o strobes wrong", $time); end

	// ----------------------------------------
	// stimulus, always applied on the falling edge
	task automatic idle_inputs();
		{cpu_rd, cpu_wr, cpu_uds, cpu_lds, cpu_idle, ram_640k} = '0;
		cpu_addr = '0;
		cpu_wdata = '0;
		{mem_rdata, zx8302_rdata, qimi_rdata} = '0;
		video_addr = '0;
		{video_rd, mdv_read, mdv2_read, mdv_seldrive} = '0;
		mdv_addr = '0;
		mdv2_addr = '0;
		{dio_download, dio_strobe} = '0;
		dio_index = 5'd5;  // not a rom image
		dio_addr = '0;
		dio_data = '0;
	endtask

	task automatic decode_cycles(int n);
		int rw;
		for (int i = 0; i < n; i++) begin
			@(negedge clk2);
			case ($urandom_range(0, 3))
				0: cpu_addr = cpu_addr_t'($urandom);
				1: cpu_addr = 20'h18000 | cpu_addr_t'($urandom_range(0, 'h3fff));  // i/o area
				2: cpu_addr = 20'h1bf00 | cpu_addr_t'($urandom_range(0, 'hff));    // mouse
				default: cpu_addr = 20'h18000 | cpu_addr_t'($urandom_range(0, 'h7f));
			endcase
			rw = $urandom_range(0, 2);
			cpu_rd = (rw == 0);
			cpu_wr = (rw == 1);
			cpu_uds = $urandom_range(0, 1);
			cpu_lds = $urandom_range(0, 1);
			cpu_idle = $urandom_range(0, 1);
			ram_640k = (i >= n / 2);  // second half with extended ram
			cpu_wdata = bus_data_t'($urandom);
			mem_rdata = bus_data_t'($urandom);
			zx8302_rdata = bus_data_t'($urandom);
			qimi_rdata = 8'($urandom);
			video_addr = video_addr_t'($urandom);
			video_rd = $urandom_range(0, 1);
		end
	endtask

	task automatic slot_cycles(int n, logic with_mdv);
		int pick;
		for (int i = 0; i < n; i++) begin
			@(negedge clk2);
			video_addr = video_addr_t'($urandom);
			video_rd = $urandom_range(0, 1);
			pick = with_mdv ? $urandom_range(0, 2) : 0;
			mdv_read = (pick == 1);   // one drive reading at a time
			mdv2_read = (pick == 2);
			mdv_seldrive = $urandom_range(0, 1);
			mdv_addr = sys_addr_t'($urandom);
			mdv2_addr = sys_addr_t'($urandom);
		end
	endtask

	task automatic wait_drained();
		while (m_fifo.size() != 0)
			@(negedge clk2);
		repeat (2) @(negedge clk2);
	endtask

	// gap 1 strobes every second clock, gap 0 on every clock
	task automatic download_writes(int n, logic gap);
		@(negedge clk2);
		dio_download = 1'b1;
		for (int i = 0; i < n; i++) begin
			dio_strobe = 1'b1;
			dio_addr = sys_addr_t'($urandom);
			dio_data = bus_data_t'($urandom);
			@(negedge clk2);
			if (gap) begin
				dio_strobe = 1'b0;
				@(negedge clk2);
			end
		end
		dio_strobe = 1'b0;
		wait_drained();
		dio_download = 1'b0;
	endtask

	task automatic rom_reset_hold();
		int held;
		held = 0;
		@(negedge clk2);
		dio_index = 5'd3;
		dio_download = 1'b1;
		repeat (5) @(negedge clk2);
		dio_download = 1'b0;
		while (core_reset) begin
			held++;
			@(negedge clk2);
		end
		assert (held == RESET_HOLD_CYCLES)
			else begin
				errors++;
				$display("Error at %0t: core_reset held %0d clocks, expected %0d",
					$time, held, RESET_HOLD_CYCLES);
			end
	endtask

	task automatic finish_test(string name, int err_before);
		@(negedge clk2);
		idle_inputs();
		repeat (2) @(negedge clk2);  // let the last request reach the checks
		tests++;
		if (errors > err_before) begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end else
			$display("test %s: ok", name);
	endtask

	// ----------------------------------------
	initial begin : main
		int e0;
		void'($urandom(59));
		errors = 0;
		tests = 0;
		failed = 0;
		idle_inputs();
		reset = 1'b1;
		repeat (10) @(negedge clk2);
		reset = 1'b0;

		e0 = errors;
		decode_cycles(300);
		finish_test("address decode", e0);
		e0 = errors;
		slot_cycles(40, 1'b0);
		finish_test("slot alternation", e0);
		e0 = errors;
		slot_cycles(40, 1'b1);
		finish_test("microdrive priority", e0);
		e0 = errors;
		download_writes(12, 1'b1);
		assert (!dl_overflow)
			else begin errors++; $display("Error at %0t: overflow on paced writes", $time); end
		finish_test("download path", e0);
		e0 = errors;
		download_writes(12, 1'b0);
		assert (dl_overflow)
			else begin errors++; $display("Error at %0t: burst did not overflow", $time); end
		finish_test("overflow", e0);
		e0 = errors;
		rom_reset_hold();
		finish_test("core reset", e0);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// run limit
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk2);
			cycles++;
		end
		$display("timeout: run did not finish within %0d clocks", MAX_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== ql_memory_bus.f ====
src/ql_pkg.sv
src/mem_req_if.sv
src/cpu_bus_decoder.sv
src/download_fifo.sv
src/slot_scheduler.sv
src/reset_sequencer.sv
src/ql_memory_bus.sv
bench/tb_ql_memory_bus.sv

// ==== Bender.yml ====
package:
  name: ql_memory_bus

sources:
  - src/ql_pkg.sv
  - src/mem_req_if.sv
  - src/cpu_bus_decoder.sv
  - src/download_fifo.sv
  - src/slot_scheduler.sv
  - src/reset_sequencer.sv
  - src/ql_memory_bus.sv
  - target: simulation
    files:
      - bench/tb_ql_memory_bus.sv
